// ==== axi_mem_bridge.f ====
+incdir+hdl
hdl/axi_mem_pkg.sv
hdl/fall_through_fifo.sv
hdl/burst_walker.sv
hdl/rw_arbiter.sv
hdl/bank_splitter.sv
hdl/resp_composer.sv
hdl/axi_mem_bridge.sv
dv/bank_mem_model.sv
dv/tb_axi_mem_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_axi_mem_bridge \
  -f axi_mem_bridge.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== dv/tb_axi_mem_bridge.sv ====
// Runs a fixed table of INCR bursts; paired rows run together and must not touch the same bytes.
`include "axi_mem_consts.svh"

module tb_axi_mem_bridge;

  localparam int AW = `AXM_ADDR_WIDTH;
  localparam int DW = `AXM_DATA_WIDTH;
  localparam int NumRows = 17;
  localparam int Timeout = 200;
  // Every R beat and B response reports OKAY.
  localparam logic [1:0] RespOkay = 2'b00;

  // One burst; par issues it together with the next row.
  typedef struct packed {
    logic                     wr;
    logic [`AXM_ID_WIDTH-1:0] id;
    logic [AW-1:0]            addr;
    logic [7:0]               len;
    logic [2:0]               size;
    logic [3:0]               qos;
    logic [31:0]              seed;
    logic [DW/8-1:0]          strb;
    logic                     bp;
    logic                     par;
  } row_t;

  // Columns are wr, id, addr, len, size, qos, data seed, strb, back-pressure, paired.
  row_t tbl [NumRows] = '{
    '{1'b1, 4'd1,  16'h0100, 8'd0,  3'd3, 4'd0, 32'h1111_0001, 8'hff, 1'b0, 1'b0},
    '{1'b0, 4'd2,  16'h0100, 8'd0,  3'd3, 4'd0, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd3,  16'h0200, 8'd3,  3'd3, 4'd0, 32'h2222_0002, 8'hff, 1'b0, 1'b0},
    '{1'b0, 4'd4,  16'h0200, 8'd3,  3'd3, 4'd0, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd5,  16'h0300, 8'd3,  3'd2, 4'd0, 32'h3333_0003, 8'h69, 1'b0, 1'b0},
    '{1'b0, 4'd6,  16'h0300, 8'd1,  3'd3, 4'd0, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd7,  16'h0403, 8'd7,  3'd2, 4'd0, 32'h4444_0004, 8'hff, 1'b0, 1'b0},
    '{1'b0, 4'd8,  16'h0400, 8'd3,  3'd3, 4'd0, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd9,  16'h0800, 8'd3,  3'd3, 4'd2, 32'h5555_0005, 8'hff, 1'b0, 1'b1},
    '{1'b0, 4'd10, 16'h0c00, 8'd3,  3'd3, 4'd7, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd11, 16'h0900, 8'd0,  3'd3, 4'd4, 32'h6666_0006, 8'hff, 1'b0, 1'b1},
    '{1'b0, 4'd12, 16'h0200, 8'd3,  3'd3, 4'd4, 32'h0,         8'h00, 1'b0, 1'b0},
    '{1'b1, 4'd13, 16'h1000, 8'd15, 3'd3, 4'd1, 32'h7777_0007, 8'hff, 1'b1, 1'b0},
    '{1'b0, 4'd14, 16'h1000, 8'd15, 3'd3, 4'd1, 32'h0,         8'h00, 1'b1, 1'b0},
    '{1'b1, 4'd15, 16'h1100, 8'd5,  3'd2, 4'd0, 32'h8888_0008, 8'ha5, 1'b1, 1'b1},
    '{1'b0, 4'd0,  16'h1000, 8'd7,  3'd3, 4'd3, 32'h0,         8'h00, 1'b1, 1'b0},
    '{1'b0, 4'd1,  16'h1100, 8'd2,  3'd3, 4'd0, 32'h0,         8'h00, 1'b1, 1'b0}
  };

  logic                   clk;
  logic                   arst_n = 1'b0;
  axi_mem_pkg::aw_chan_t  aw, ar;
  axi_mem_pkg::w_chan_t   w;
  logic                   aw_valid, w_valid, ar_valid;
  logic                   r_ready = 1'b0;
  logic                   b_ready = 1'b0;
  logic                   bp_on = 1'b0;
  logic [31:0]            bp_rnd = 32'hf9273845;
  axi_mem_pkg::axi_req_t  axi_req;
  axi_mem_pkg::axi_resp_t axi_resp;
  axi_mem_pkg::bank_req_t [`AXM_NUM_BANKS-1:0]    bank_req;
  logic [`AXM_NUM_BANKS-1:0]                      bank_valid, bank_gnt, bank_rvalid;
  logic [`AXM_NUM_BANKS-1:0][`AXM_BANK_WIDTH-1:0] bank_rdata;
  // Expected memory contents, one byte per address.
  logic [7:0] shadow [2**AW];
  int data_errs, id_errs, last_errs, resp_errs, count_errs, timeouts;
  int exp_r, exp_b;
  int r_total = 0;
  int b_total = 0;

  assign axi_req = axi_mem_pkg::axi_req_t'{
    aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid,
    ar: ar, ar_valid: ar_valid, r_ready: r_ready, b_ready: b_ready
  };

  axi_mem_bridge i_dut (
    .clk_i(clk), .arst_n_i(arst_n), .axi_req_i(axi_req), .axi_resp_o(axi_resp),
    .bank_req_o(bank_req), .bank_valid_o(bank_valid), .bank_gnt_i(bank_gnt),
    .bank_rvalid_i(bank_rvalid), .bank_rdata_i(bank_rdata)
  );

  bank_mem_model i_banks (
    .clk_i(clk), .arst_n_i(arst_n), .req_i(bank_req), .valid_i(bank_valid),
    .gnt_o(bank_gnt), .rvalid_o(bank_rvalid), .rdata_o(bank_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random R and B readiness only on back-pressure rows.
  always @(posedge clk) begin
    bp_rnd  <= next_rand(bp_rnd);
    r_ready <= !bp_on || bp_rnd[20];
    b_ready <= !bp_on || bp_rnd[27];
  end

  // Every R and B handshake, counted the half cycle before its edge.
  always @(negedge clk) begin
    if (axi_resp.r_valid && r_ready) r_total++;
    if (axi_resp.b_valid && b_ready) b_total++;
  end

  // First beat at the request address, later ones on size steps from its aligned base.
  function automatic logic [AW-1:0] beat_addr(input logic [AW-1:0] start,
                                              input logic [2:0] size, input int n);
    logic [AW-1:0] step;
    step = AW'(1) << size;
    if (n == 0) return start;
    return (start & ~(step - AW'(1))) + AW'(n) * step;
  endfunction

  // Byte lanes that a beat of this size at this address may use.
  function automatic logic [DW/8-1:0] lane_mask(input logic [AW-1:0] a, input logic [2:0] size);
    int nbytes;
    int lane;
    nbytes = 1 << size;
    lane   = int'(a[2:0]) & ~(nbytes - 1);
    return (DW/8)'(((1 << nbytes) - 1) << lane);
  endfunction

  function automatic logic [DW-1:0] beat_data(input logic [31:0] seed, input int n);
    return {next_rand(seed ^ 32'(n)), next_rand(seed + 32'(n))};
  endfunction

  // Whole bus word holding this address.
  function automatic logic [DW-1:0] shadow_word(input logic [AW-1:0] a);
    logic [DW-1:0] word;
    logic [AW-1:0] base;
    base = a & ~AW'(DW/8 - 1);
    for (int k = 0; k < DW/8; k++) word[8*k +: 8] = shadow[base + AW'(k)];
    return word;
  endfunction

  task automatic check_data(input logic [DW-1:0] got, exp, input string name);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_id(input logic [`AXM_ID_WIDTH-1:0] got, exp, input string name);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      id_errs++;
    end
  endtask

  task automatic check_last(input logic got, exp, input string name);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      last_errs++;
    end
  endtask

  task automatic check_resp(input logic [1:0] got, exp, input string name);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_count(input int got, exp, input string name);
    if (got != exp) begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      count_errs++;
    end
  endtask

  // Channel codes are 0 AW with W, 1 W, 2 AR, 3 R, 4 B.
  function automatic bit ready_of(input int ch);
    case (ch)
      0: return axi_resp.aw_ready && axi_resp.w_ready;
      1: return axi_resp.w_ready;
      2: return axi_resp.ar_ready;
      3: return axi_resp.r_valid && r_ready;
      default: return axi_resp.b_valid && b_ready;
    endcase
  endfunction

  // Returns at the negedge before the transfer edge.
  task automatic await_ready(input int ch, input string what, output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready_of(ch) && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    ok = ready_of(ch);
    if (!ok) begin
      $display("Timeout at time %0t: %s did not happen within %0d cycles", $time, what, Timeout);
      timeouts++;
    end
  endtask

  task automatic send_write(input row_t r);
    logic [AW-1:0]   a;
    logic [DW-1:0]   d;
    logic [DW/8-1:0] s;
    bit              ok;
    for (int n = 0; n <= int'(r.len); n++) begin
      a = beat_addr(r.addr, r.size, n);
      d = beat_data(r.seed, n);
      s = r.strb & lane_mask(a, r.size);
      @(posedge clk);
      aw       <= axi_mem_pkg::aw_chan_t'{
        id: r.id, addr: r.addr, len: r.len, size: r.size, burst: 2'b01, qos: r.qos
      };
      aw_valid <= (n == 0);
      w        <= axi_mem_pkg::w_chan_t'{data: d, strb: s, last: (n == int'(r.len))};
      w_valid  <= 1'b1;
      await_ready((n == 0) ? 0 : 1, "write beat handshake", ok);
      if (!ok) break;
      // Same byte placement as the bank split.
      for (int k = 0; k < DW/8; k++) begin
        if (s[k]) shadow[(a & ~AW'(DW/8 - 1)) + AW'(k)] = d[8*k +: 8];
      end
    end
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
  endtask

  task automatic send_read(input row_t r);
    bit ok;
    @(posedge clk);
    ar       <= axi_mem_pkg::aw_chan_t'{
      id: r.id, addr: r.addr, len: r.len, size: r.size, burst: 2'b01, qos: r.qos
    };
    ar_valid <= 1'b1;
    await_ready(2, "AR handshake", ok);
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  task automatic collect_r(input row_t r);
    bit ok;
    for (int n = 0; n <= int'(r.len); n++) begin
      await_ready(3, "R beat", ok);
      if (!ok) break;
      check_data(axi_resp.r.data, shadow_word(beat_addr(r.addr, r.size, n)), "r.data");
      check_id(axi_resp.r.id, r.id, "r.id");
      check_last(axi_resp.r.last, n == int'(r.len), "r.last");
      check_resp(axi_resp.r.resp, RespOkay, "r.resp");
    end
  endtask

  task automatic collect_b(input row_t r);
    bit ok;
    await_ready(4, "B response", ok);
    if (ok) begin
      check_id(axi_resp.b.id, r.id, "b.id");
      check_resp(axi_resp.b.resp, RespOkay, "b.resp");
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    r     = tbl[idx];
    bp_on = r.bp;
    if (r.wr) begin
      fork
        send_write(r);
        collect_b(r);
      join
      exp_b++;
    end else begin
      fork
        send_read(r);
        collect_r(r);
      join
      exp_r += int'(r.len) + 1;
    end
  endtask

  initial begin
    int i;
    aw       = '0;
    ar       = '0;
    w        = '0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    ar_valid = 1'b0;
    for (int a = 0; a < 2**AW; a++) shadow[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    i = 0;
    while (i < NumRows && timeouts == 0) begin
      if (tbl[i].par && i + 1 < NumRows) begin
        fork
          run_row(i);
          run_row(i + 1);
        join
        i += 2;
      end else begin
        run_row(i);
        i++;
      end
    end
    // Room for a stray extra response to show up in the totals.
    repeat (20) @(posedge clk);
    check_count(r_total, exp_r, "R beat count");
    check_count(b_total, exp_b, "B response count");
    $display("Errors: data %0d, id %0d, last %0d, resp %0d, count %0d, timeouts %0d",
             data_errs, id_errs, last_errs, resp_errs, count_errs, timeouts);
    if (data_errs + id_errs + last_errs + resp_errs + count_errs + timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== dv/bank_mem_model.sv ====
// Both banks share one byte array; grants are random and every grant answers one cycle later.
`include "axi_mem_consts.svh"

module bank_mem_model #(
  parameter logic [31:0] Seed = 32'hf9273845
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  axi_mem_pkg::bank_req_t [`AXM_NUM_BANKS-1:0]    req_i,
  input  logic [`AXM_NUM_BANKS-1:0]                      valid_i,
  output logic [`AXM_NUM_BANKS-1:0]                      gnt_o,
  output logic [`AXM_NUM_BANKS-1:0]                      rvalid_o,
  output logic [`AXM_NUM_BANKS-1:0][`AXM_BANK_WIDTH-1:0] rdata_o
);

  localparam int NumBytes = `AXM_BANK_WIDTH / 8;

  logic [7:0]  mem [2**`AXM_ADDR_WIDTH];
  logic [31:0] rnd_q;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every byte starts from a pattern of its full address.
  initial begin
    for (int a = 0; a < 2**`AXM_ADDR_WIDTH; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rnd_q    <= Seed;
      gnt_o    <= '0;
      rvalid_o <= '0;
    end else begin
      rnd_q <= next_rand(rnd_q);
      for (int i = 0; i < `AXM_NUM_BANKS; i++) begin
        // Grant about three cycles in four.
        gnt_o[i]    <= (rnd_q[16 + 2*i +: 2] != 2'b00);
        rvalid_o[i] <= valid_i[i] & gnt_o[i];
        if (valid_i[i] && gnt_o[i]) begin
          for (int k = 0; k < NumBytes; k++) begin
            rdata_o[i][8*k +: 8] <= mem[req_i[i].addr + `AXM_ADDR_WIDTH'(k)];
          end
        end
      end
    end
  end

  // Writes land by strobe on the grant edge.
  always @(posedge clk_i) begin
    for (int i = 0; i < `AXM_NUM_BANKS; i++) begin
      if (arst_n_i && valid_i[i] && gnt_o[i] && req_i[i].we) begin
        for (int k = 0; k < NumBytes; k++) begin
          if (req_i[i].strb[k]) begin
            mem[req_i[i].addr + `AXM_ADDR_WIDTH'(k)] <= req_i[i].wdata[8*k +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== hdl/axi_mem_bridge.sv ====
// AXI4 slave to two-bank memory; INCR bursts only, burst field ignored, every response OKAY.
`include "axi_mem_consts.svh"

module axi_mem_bridge (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  axi_mem_pkg::axi_req_t                          axi_req_i,
  output axi_mem_pkg::axi_resp_t                         axi_resp_o,
  output axi_mem_pkg::bank_req_t [`AXM_NUM_BANKS-1:0]    bank_req_o,
  output logic [`AXM_NUM_BANKS-1:0]                      bank_valid_o,
  input  logic [`AXM_NUM_BANKS-1:0]                      bank_gnt_i,
  input  logic [`AXM_NUM_BANKS-1:0]                      bank_rvalid_i,
  input  logic [`AXM_NUM_BANKS-1:0][`AXM_BANK_WIDTH-1:0] bank_rdata_i
);

  axi_mem_pkg::meta_t     rd_beat, wr_beat, arb_meta, buf_meta;
  axi_mem_pkg::mem_req_t  mem_req;
  axi_mem_pkg::axi_resp_t comp_resp;
  logic                   rd_beat_valid, rd_beat_ready, rd_busy;
  logic                   wr_beat_valid, wr_beat_ready, wr_busy;
  logic                   ar_ready, aw_ready, w_ready;
  logic                   arb_meta_valid, arb_meta_ready, mem_valid, mem_ready;
  logic                   buf_valid, buf_ready;
  logic [`AXM_DATA_WIDTH-1:0] rdata;
  logic                   rvalid, rready;

  // Read beats; AR carries no data, so data is always present.
  burst_walker #(.IsWrite(1'b0)) i_rd_walker (
    .clk_i, .arst_n_i,
    .ax_i(axi_req_i.ar), .ax_valid_i(axi_req_i.ar_valid), .ax_ready_o(ar_ready),
    .data_valid_i(1'b1), .data_ready_o(),
    .beat_o(rd_beat), .beat_valid_o(rd_beat_valid), .beat_ready_i(rd_beat_ready),
    .busy_o(rd_busy)
  );

  // Write beats, one per W transfer.
  burst_walker #(.IsWrite(1'b1)) i_wr_walker (
    .clk_i, .arst_n_i,
    .ax_i(axi_req_i.aw), .ax_valid_i(axi_req_i.aw_valid), .ax_ready_o(aw_ready),
    .data_valid_i(axi_req_i.w_valid), .data_ready_o(w_ready),
    .beat_o(wr_beat), .beat_valid_o(wr_beat_valid), .beat_ready_i(wr_beat_ready),
    .busy_o(wr_busy)
  );

  rw_arbiter i_rw_arbiter (
    .clk_i, .arst_n_i,
    .rd_i(rd_beat), .rd_valid_i(rd_beat_valid), .rd_ready_o(rd_beat_ready), .rd_busy_i(rd_busy),
    .wr_i(wr_beat), .wr_valid_i(wr_beat_valid), .wr_ready_o(wr_beat_ready), .wr_busy_i(wr_busy),
    .w_i(axi_req_i.w),
    .meta_o(arb_meta), .meta_valid_o(arb_meta_valid), .meta_ready_i(arb_meta_ready),
    .mem_o(mem_req), .mem_valid_o(mem_valid), .mem_ready_i(mem_ready)
  );

  // Covers every beat in flight plus the one waiting to join.
  fall_through_fifo #(
    .Width($bits(axi_mem_pkg::meta_t)), .Depth(`AXM_BUF_DEPTH + 1)
  ) i_meta_buf (
    .clk_i, .arst_n_i,
    .data_i(arb_meta), .valid_i(arb_meta_valid), .ready_o(arb_meta_ready),
    .data_o(buf_meta), .valid_o(buf_valid), .ready_i(buf_ready)
  );

  bank_splitter i_bank_splitter (
    .clk_i, .arst_n_i,
    .req_i(mem_req), .req_valid_i(mem_valid), .req_ready_o(mem_ready),
    .rdata_o(rdata), .rvalid_o(rvalid), .rready_i(rready),
    .bank_req_o, .bank_valid_o, .bank_gnt_i, .bank_rvalid_i, .bank_rdata_i
  );

  resp_composer i_resp_composer (
    .meta_i(buf_meta), .meta_valid_i(buf_valid), .meta_ready_o(buf_ready),
    .rdata_i(rdata), .rvalid_i(rvalid), .rready_o(rready),
    .axi_req_i, .resp_o(comp_resp)
  );

  // Request-side readies come from the walkers, R and B from the composer.
  assign axi_resp_o = axi_mem_pkg::axi_resp_t'{
    aw_ready: aw_ready, w_ready: w_ready, ar_ready: ar_ready,
    r: comp_resp.r, r_valid: comp_resp.r_valid,
    b: comp_resp.b, b_valid: comp_resp.b_valid
  };

endmodule

// ==== hdl/resp_composer.sv ====
// Drives only the R and B fields of resp_o; the request readies there stay low for the top to fill.
`include "axi_mem_consts.svh"

module resp_composer (
  input  axi_mem_pkg::meta_t         meta_i,
  input  logic                       meta_valid_i,
  output logic                       meta_ready_o,
  input  logic [`AXM_DATA_WIDTH-1:0] rdata_i,
  input  logic                       rvalid_i,
  output logic                       rready_o,
  input  axi_mem_pkg::axi_req_t      axi_req_i,
  output axi_mem_pkg::axi_resp_t     resp_o
);

  logic both, to_r, to_b, out_ready, fire;

  // Reads always answer; writes only on the burst's last beat.
  assign to_r = ~meta_i.write;
  assign to_b = meta_i.write & meta_i.last;
  assign both = meta_valid_i & rvalid_i;

  // Middle write beats need no channel and drain freely.
  assign out_ready = to_r ? axi_req_i.r_ready :
                     to_b ? axi_req_i.b_ready : 1'b1;
  assign fire      = both & out_ready;

  // Both inputs pop together.
  assign meta_ready_o = fire;
  assign rready_o     = fire;

  always_comb begin
    resp_o         = '0;
    resp_o.r.data  = rdata_i;
    resp_o.r.id    = meta_i.id;
    resp_o.r.last  = meta_i.last;
    // OKAY.
    resp_o.r.resp  = 2'b00;
    resp_o.r_valid = both & to_r;
    resp_o.b.id    = meta_i.id;
    resp_o.b.resp  = 2'b00;
    resp_o.b_valid = both & to_b;
  end

endmodule

// ==== hdl/bank_splitter.sv ====
// Banks must answer every granted request exactly once and in order; rvalid cannot be stalled.
`include "axi_mem_consts.svh"

module bank_splitter (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  axi_mem_pkg::mem_req_t                          req_i,
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  output logic [`AXM_DATA_WIDTH-1:0]                     rdata_o,
  output logic                                           rvalid_o,
  input  logic                                           rready_i,
  output axi_mem_pkg::bank_req_t [`AXM_NUM_BANKS-1:0]    bank_req_o,
  output logic [`AXM_NUM_BANKS-1:0]                      bank_valid_o,
  input  logic [`AXM_NUM_BANKS-1:0]                      bank_gnt_i,
  input  logic [`AXM_NUM_BANKS-1:0]                      bank_rvalid_i,
  input  logic [`AXM_NUM_BANKS-1:0][`AXM_BANK_WIDTH-1:0] bank_rdata_i
);

  localparam int unsigned NumBanks = `AXM_NUM_BANKS;
  localparam int unsigned BankW    = `AXM_BANK_WIDTH;
  localparam int unsigned SelW     = $clog2(NumBanks);
  localparam int unsigned CntW     = $clog2(`AXM_BUF_DEPTH + 1);

  axi_mem_pkg::bank_req_t [NumBanks-1:0] bank_in;
  logic [NumBanks-1:0]                   req_rdy, resp_rdy, resp_vld;
  logic [CntW-1:0]                       cnt_q;
  logic                                  accept, retire;

  // Requests whose joined response has not left yet.
  // The bound keeps room in every response FIFO for each rvalid.
  assign accept      = req_valid_i & req_ready_o;
  assign retire      = rvalid_o & rready_i;
  assign req_ready_o = (&req_rdy) & (&resp_rdy) & (cnt_q != CntW'(`AXM_BUF_DEPTH));
  // Joined word is ready once every bank holds its half.
  assign rvalid_o    = &resp_vld;

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    axi_mem_pkg::mem_addr_u bank_addr;

    // Same bus word, this bank's slot, first byte.
    always_comb begin
      bank_addr              = req_i.addr;
      bank_addr.field.bank   = SelW'(i);
      bank_addr.field.offset = '0;
    end

    assign bank_in[i] = axi_mem_pkg::bank_req_t'{
      addr:  bank_addr.byte_addr,
      wdata: req_i.wdata[i*BankW +: BankW],
      strb:  req_i.strb[i*BankW/8 +: BankW/8],
      we:    req_i.we
    };

    fall_through_fifo #(
      .Width($bits(axi_mem_pkg::bank_req_t)), .Depth(`AXM_BUF_DEPTH)
    ) i_req_fifo (
      .clk_i, .arst_n_i,
      .data_i(bank_in[i]), .valid_i(accept), .ready_o(req_rdy[i]),
      .data_o(bank_req_o[i]), .valid_o(bank_valid_o[i]), .ready_i(bank_gnt_i[i])
    );

    // Writes return a response too, so both banks pop together.
    fall_through_fifo #(
      .Width(BankW), .Depth(`AXM_BUF_DEPTH)
    ) i_resp_fifo (
      .clk_i, .arst_n_i,
      .data_i(bank_rdata_i[i]), .valid_i(bank_rvalid_i[i]), .ready_o(resp_rdy[i]),
      .data_o(rdata_o[i*BankW +: BankW]), .valid_o(resp_vld[i]), .ready_i(retire)
    );
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + CntW'(accept) - CntW'(retire);
    end
  end

endmodule

// ==== hdl/rw_arbiter.sv ====
// Offers must hold until taken; a stalled choice stays locked, so neither side may drop its valid.
module rw_arbiter (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  axi_mem_pkg::meta_t    rd_i,
  input  logic                  rd_valid_i,
  output logic                  rd_ready_o,
  input  logic                  rd_busy_i,
  input  axi_mem_pkg::meta_t    wr_i,
  input  logic                  wr_valid_i,
  output logic                  wr_ready_o,
  input  logic                  wr_busy_i,
  input  axi_mem_pkg::w_chan_t  w_i,
  output axi_mem_pkg::meta_t    meta_o,
  output logic                  meta_valid_o,
  input  logic                  meta_ready_i,
  output axi_mem_pkg::mem_req_t mem_o,
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i
);

  logic       sel_d, sel_q, lock_q;
  logic       arb_valid, arb_ready;
  // Bit 0 is the meta branch, bit 1 the memory branch.
  logic [1:0] done_d, done_q;

  // Select is high for writes.
  always_comb begin
    sel_d = sel_q;
    if (lock_q) begin
      sel_d = sel_q;
    end else if (rd_valid_i ^ wr_valid_i) begin
      sel_d = wr_valid_i;
    end else if (rd_valid_i && wr_valid_i) begin
      // Higher QoS first.
      if (wr_i.qos != rd_i.qos) begin
        sel_d = (wr_i.qos > rd_i.qos);
      // A single write ahead of a read burst.
      end else if (wr_i.last && !rd_i.last) begin
        sel_d = 1'b1;
      // Then keep a burst going.
      end else if (wr_busy_i || rd_busy_i) begin
        sel_d = wr_busy_i;
      end else begin
        sel_d = ~sel_q;
      end
    end
  end

  assign arb_valid  = sel_d ? wr_valid_i : rd_valid_i;
  assign meta_o     = sel_d ? wr_i : rd_i;
  assign rd_ready_o = ~sel_d & arb_ready;
  assign wr_ready_o = sel_d & arb_ready;

  // Fork; a branch that has taken the beat stops offering it.
  assign meta_valid_o = arb_valid & ~done_q[0];
  assign mem_valid_o  = arb_valid & ~done_q[1];
  assign arb_ready    = (meta_ready_i | done_q[0]) & (mem_ready_i | done_q[1]);
  assign done_d       = (arb_valid && arb_ready) ? 2'b00 :
                        done_q | {mem_valid_o & mem_ready_i, meta_valid_o & meta_ready_i};

  // W data rides with the beat; reads ignore it.
  assign mem_o = axi_mem_pkg::mem_req_t'{
    addr: meta_o.addr, wdata: w_i.data, strb: w_i.strb, we: meta_o.write
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
      done_q <= 2'b00;
    end else begin
      sel_q  <= sel_d;
      lock_q <= arb_valid & ~arb_ready;
      done_q <= done_d;
    end
  end

endmodule

// ==== hdl/burst_walker.sv ====
// Treats every burst as INCR and does not check 4 KiB crossing; the address wraps at 64 KiB.
`include "axi_mem_consts.svh"

module burst_walker #(
  parameter bit IsWrite = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  axi_mem_pkg::aw_chan_t ax_i,
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  input  logic                  data_valid_i,
  output logic                  data_ready_o,
  output axi_mem_pkg::meta_t    beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  output logic                  busy_o
);

  logic [7:0]                 cnt_d, cnt_q;
  axi_mem_pkg::meta_t         cur_d, cur_q;
  logic [`AXM_ADDR_WIDTH-1:0] step, aligned;

  // Beat size in bytes, and the last beat's address rounded down to it.
  assign step    = `AXM_ADDR_WIDTH'(1) << cur_q.size;
  assign aligned = cur_q.addr.byte_addr & ~(step - `AXM_ADDR_WIDTH'(1));
  // Beats left after the one in cur_q.
  assign busy_o  = (cnt_q != 8'd0);

  always_comb begin
    cnt_d        = cnt_q;
    cur_d        = cur_q;
    beat_o       = cur_q;
    beat_valid_o = 1'b0;
    ax_ready_o   = 1'b0;
    data_ready_o = 1'b0;
    if (busy_o) begin
      // Later beats start on a size boundary.
      beat_o.addr.byte_addr = aligned + step;
      beat_o.last           = (cnt_q == 8'd1);
      beat_valid_o          = data_valid_i;
      if (data_valid_i && beat_ready_i) begin
        data_ready_o = 1'b1;
        cnt_d        = cnt_q - 8'd1;
        cur_d        = beat_o;
      end
    end else if (ax_valid_i) begin
      // First beat keeps the unaligned request address.
      beat_o.addr.byte_addr = ax_i.addr;
      beat_o.id             = ax_i.id;
      beat_o.last           = (ax_i.len == 8'd0);
      beat_o.qos            = ax_i.qos;
      beat_o.size           = ax_i.size;
      beat_o.write          = IsWrite;
      beat_valid_o          = data_valid_i;
      // Address and first data beat are taken together.
      if (data_valid_i && beat_ready_i) begin
        ax_ready_o   = 1'b1;
        data_ready_o = 1'b1;
        cnt_d        = ax_i.len;
        cur_d        = beat_o;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= 8'd0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

endmodule

// ==== hdl/fall_through_fifo.sv ====
// Data passes through in the same cycle when empty; a full FIFO does not accept while it pops.
module fall_through_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [Width-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [Width-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             empty, push, pop;

  assign empty   = (cnt_q == '0);
  assign ready_o = (cnt_q != CntW'(Depth));
  assign valid_o = !empty || valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];
  // A word taken straight through is never stored.
  assign push    = valid_i && ready_o && !(empty && ready_i);
  assign pop     = !empty && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/axi_mem_pkg.sv ====
// Types for the AXI to banked memory bridge; no user or atop fields, responses carry OKAY only.
`include "axi_mem_consts.svh"

package axi_mem_pkg;

  // One byte address, read either whole or split into word, bank and byte.
  typedef union packed {
    logic [`AXM_ADDR_WIDTH-1:0] byte_addr;
    struct packed {
      logic [`AXM_ADDR_WIDTH-$clog2(`AXM_DATA_WIDTH/8)-1:0] word;
      logic [$clog2(`AXM_NUM_BANKS)-1:0]                     bank;
      logic [$clog2(`AXM_BANK_WIDTH/8)-1:0]                  offset;
    } field;
  } mem_addr_u;

  // AR and AW share this layout.
  typedef struct packed {
    logic [`AXM_ID_WIDTH-1:0]   id;
    logic [`AXM_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
    logic [3:0]                 qos;
  } aw_chan_t;

  typedef struct packed {
    logic [`AXM_DATA_WIDTH-1:0]   data;
    logic [`AXM_DATA_WIDTH/8-1:0] strb;
    logic                         last;
  } w_chan_t;

  typedef struct packed {
    logic [`AXM_DATA_WIDTH-1:0] data;
    logic [`AXM_ID_WIDTH-1:0]   id;
    logic                       last;
    logic [1:0]                 resp;
  } r_chan_t;

  typedef struct packed {
    logic [`AXM_ID_WIDTH-1:0] id;
    logic [1:0]               resp;
  } b_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    aw_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
    logic     b_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
    b_chan_t b;
    logic    b_valid;
  } axi_resp_t;

  // Per-beat record, kept until the memory answers.
  typedef struct packed {
    mem_addr_u                addr;
    logic [`AXM_ID_WIDTH-1:0] id;
    logic                     last;
    logic [3:0]               qos;
    logic [2:0]               size;
    logic                     write;
  } meta_t;

  typedef struct packed {
    mem_addr_u                    addr;
    logic [`AXM_DATA_WIDTH-1:0]   wdata;
    logic [`AXM_DATA_WIDTH/8-1:0] strb;
    logic                         we;
  } mem_req_t;

  typedef struct packed {
    logic [`AXM_ADDR_WIDTH-1:0]   addr;
    logic [`AXM_BANK_WIDTH-1:0]   wdata;
    logic [`AXM_BANK_WIDTH/8-1:0] strb;
    logic                         we;
  } bank_req_t;

endpackage

// ==== hdl/axi_mem_consts.svh ====
// Sizing assumes a 64-bit bus over two 32-bit banks; the bank width times bank count must equal the bus width.
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Byte address width of the AXI port and the banks.
`define AXM_ADDR_WIDTH 16

// AXI data width in bits.
`define AXM_DATA_WIDTH 64

// AXI id width.
`define AXM_ID_WIDTH 4

// Number of memory banks.
`define AXM_NUM_BANKS 2

// Data width of one bank.
`define AXM_BANK_WIDTH 32

// Responses in flight toward the banks; the meta buffer holds one more.
`define AXM_BUF_DEPTH 2

`endif
